/* compile.f */
wbuf_pkg.sv
mem_pkg.sv
wbuf_store.sv
wbuf_issue.sv
wbuf_tx_track.sv
wbuf_top.sv
tb_wbuf.sv

/* mem_pkg.sv */
// memory side definitions; the data bus is one dword wide and narrow writes replicate data
package mem_pkg;

  // width of the memory write data bus
  localparam int MEM_DATA_WIDTH = 64;

  // transfer size code of a memory write
  // transfers are always aligned to their own size
  typedef enum logic [1:0] {
    SIZE_BYTE  = 2'b00,
    SIZE_HALF  = 2'b01,
    SIZE_WORD  = 2'b10,
    SIZE_DWORD = 2'b11
  } mem_size_e;

  // number of bytes moved by a transfer of the given size
  function automatic int unsigned size_bytes(mem_size_e size);
    int unsigned nbytes;
    case (size)
      SIZE_BYTE: nbytes = 1;
      SIZE_HALF: nbytes = 2;
      SIZE_WORD: nbytes = 4;
      default:   nbytes = 8;
    endcase
    return nbytes;
  endfunction

endpackage

/* tb_wbuf.sv */
// runs with the default parameters only and the tests send every write response themselves
`timescale 1ns/1ps

module tb_wbuf;

  import wbuf_pkg::*;
  import mem_pkg::*;

  localparam int Depth     = 8;
  localparam int MaxTx     = 4;
  localparam int AddrWidth = 32;
  localparam int IdWidth   = $clog2(MaxTx);
  localparam int Timeout   = 200;

  logic                      clk_i;
  logic                      rst_ni;
  logic                      wr_req_i;
  logic [AddrWidth-1:0]      wr_addr_i;
  logic [WORD_BYTES-1:0]     wr_be_i;
  logic [WORD_WIDTH-1:0]     wr_data_i;
  logic                      wr_gnt_o;
  logic                      mem_req_o;
  logic                      mem_ack_i;
  logic [AddrWidth-1:0]      mem_addr_o;
  mem_size_e                 mem_size_o;
  logic [MEM_DATA_WIDTH-1:0] mem_data_o;
  logic [IdWidth-1:0]        mem_id_o;
  logic                      rsp_vld_i;
  logic [IdWidth-1:0]        rsp_id_i;
  logic                      empty_o;

  // transfers accepted on the memory port, oldest first
  logic [AddrWidth-1:0]      xfer_addr [$];
  mem_size_e                 xfer_size [$];
  logic [MEM_DATA_WIDTH-1:0] xfer_data [$];
  logic [IdWidth-1:0]        xfer_id   [$];

  logic [15:0] lfsr_state;
  int          errors;
  int          timeouts;
  int          checks;

  wbuf_top #(
    .Depth     (Depth),
    .MaxTx     (MaxTx),
    .AddrWidth (AddrWidth)
  ) DUT (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .wr_req_i   (wr_req_i),
    .wr_addr_i  (wr_addr_i),
    .wr_be_i    (wr_be_i),
    .wr_data_i  (wr_data_i),
    .wr_gnt_o   (wr_gnt_o),
    .mem_req_o  (mem_req_o),
    .mem_ack_i  (mem_ack_i),
    .mem_addr_o (mem_addr_o),
    .mem_size_o (mem_size_o),
    .mem_data_o (mem_data_o),
    .mem_id_o   (mem_id_o),
    .rsp_vld_i  (rsp_vld_i),
    .rsp_id_i   (rsp_id_i),
    .empty_o    (empty_o)
  );

  initial clk_i = 1'b0;
  always #2 clk_i = ~clk_i;

  ////////////////////////////////////////////////////////////
  // memory model and helpers
  ////////////////////////////////////////////////////////////

  // sampled mid-cycle since the transfer happens on the next rising edge
  task automatic record_transfer();
    if (rst_ni && mem_req_o && mem_ack_i) begin
      xfer_addr.push_back(mem_addr_o);
      xfer_size.push_back(mem_size_o);
      xfer_data.push_back(mem_data_o);
      xfer_id.push_back(mem_id_o);
    end
  endtask

  always @(negedge clk_i) record_transfer();

  // fibonacci lfsr x^16+x^14+x^13+x^11+1 stepped once per bit
  function automatic logic [63:0] random_bits(input int n);
    logic [63:0] value;
    logic        fb;
    value = '0;
    for (int i = 0; i < n; i++) begin
      fb         = lfsr_state[15] ^ lfsr_state[13] ^ lfsr_state[12] ^ lfsr_state[10];
      lfsr_state = {lfsr_state[14:0], fb};
      value      = {value[62:0], fb};
    end
    return value;
  endfunction

  // nbytes starting at off repeated over the whole bus
  function automatic logic [63:0] replicate(input logic [63:0] word, input int off,
                                            input int nbytes);
    logic [63:0] result;
    for (int b = 0; b < 8; b++) begin
      result[8*b +: 8] = word[8*((b % nbytes) + off) +: 8];
    end
    return result;
  endfunction

  task automatic value_mismatch(input string name, input logic [63:0] got,
                                input logic [63:0] exp);
    $display("[ERROR] time %0t %s: got 0x%0h, expected 0x%0h", $time, name, got, exp);
    errors++;
  endtask

  task automatic timeout_hit(input string what);
    $display("timeout at %0t while waiting for %s", $time, what);
    timeouts++;
  endtask

  task automatic clear_xfers();
    xfer_addr.delete();
    xfer_size.delete();
    xfer_data.delete();
    xfer_id.delete();
  endtask

  task automatic set_ack(input logic value);
    @(posedge clk_i);
    mem_ack_i <= value;
  endtask

  // request stays up until granted
  task automatic store_word(input logic [AddrWidth-1:0] addr, input logic [7:0] be,
                            input logic [63:0] data);
    int waited;
    waited = 0;
    @(posedge clk_i);
    wr_req_i  <= 1'b1;
    wr_addr_i <= addr;
    wr_be_i   <= be;
    wr_data_i <= data;
    @(negedge clk_i);
    while (!wr_gnt_o && waited < Timeout) begin
      @(negedge clk_i);
      waited++;
    end
    if (!wr_gnt_o) begin
      timeout_hit("wr_gnt_o");
    end
    @(posedge clk_i);
    wr_req_i <= 1'b0;
  endtask

  // a new tag on a full buffer must see no grant
  task automatic refuse_new_tag(input logic [AddrWidth-1:0] addr);
    @(posedge clk_i);
    wr_req_i  <= 1'b1;
    wr_addr_i <= addr;
    wr_be_i   <= 8'hff;
    wr_data_i <= random_bits(64);
    repeat (3) begin
      @(negedge clk_i);
      checks++;
      if (wr_gnt_o !== 1'b0) begin
        value_mismatch("wr_gnt_o", wr_gnt_o, 0);
      end
    end
    @(posedge clk_i);
    wr_req_i <= 1'b0;
  endtask

  task automatic send_rsp(input logic [IdWidth-1:0] id);
    @(posedge clk_i);
    rsp_vld_i <= 1'b1;
    rsp_id_i  <= id;
    @(posedge clk_i);
    rsp_vld_i <= 1'b0;
  endtask

  // back to back responses with the highest slot first
  task automatic answer_all_reverse();
    for (int k = MaxTx - 1; k >= 0; k--) begin
      @(posedge clk_i);
      rsp_vld_i <= 1'b1;
      rsp_id_i  <= IdWidth'(k);
    end
    @(posedge clk_i);
    rsp_vld_i <= 1'b0;
  endtask

  // queue is read on the rising edge after the recorder has run
  task automatic wait_xfers(input int n);
    int waited;
    waited = 0;
    @(posedge clk_i);
    while (xfer_addr.size() < n && waited < Timeout) begin
      @(posedge clk_i);
      waited++;
    end
    if (xfer_addr.size() < n) begin
      timeout_hit($sformatf("transfer %0d", n));
    end
  endtask

  task automatic await_empty();
    int waited;
    waited = 0;
    @(negedge clk_i);
    while (!empty_o && waited < Timeout) begin
      @(negedge clk_i);
      waited++;
    end
    if (!empty_o) begin
      timeout_hit("empty_o");
    end
  endtask

  task automatic check_xfer(input int idx, input logic [AddrWidth-1:0] addr,
                            input mem_size_e size, input logic [63:0] data);
    checks++;
    if (idx >= xfer_addr.size()) begin
      $display("transfer %0d never appeared on the memory port", idx);
      errors++;
    end else begin
      if (xfer_addr[idx] !== addr) begin
        value_mismatch("mem_addr_o", xfer_addr[idx], addr);
      end
      if (xfer_size[idx] !== size) begin
        value_mismatch("mem_size_o", xfer_size[idx], size);
      end
      if (xfer_data[idx] !== data) begin
        value_mismatch("mem_data_o", xfer_data[idx], data);
      end
    end
  endtask

  task automatic xfer_count_is(input int n);
    @(posedge clk_i);
    checks++;
    if (xfer_addr.size() != n) begin
      value_mismatch("transfer count", xfer_addr.size(), n);
    end
  endtask

  ////////////////////////////////////////////////////////////
  // directed tests
  ////////////////////////////////////////////////////////////

  task automatic send_full_dword();
    logic [63:0] rnd;
    logic [63:0] data;
    logic [AddrWidth-1:0] addr;
    clear_xfers();
    rnd  = random_bits(AddrWidth);
    addr = {rnd[AddrWidth-1:3], 3'b000};
    data = random_bits(64);
    set_ack(1'b1);
    store_word(addr, 8'hff, data);
    wait_xfers(1);
    check_xfer(0, addr, SIZE_DWORD, data);
    // all slots idle so the lowest one is taken
    checks++;
    if (xfer_id[0] !== '0) begin
      value_mismatch("mem_id_o", xfer_id[0], 0);
    end
    // bytes in flight keep the buffer busy
    @(negedge clk_i);
    checks++;
    if (empty_o !== 1'b0) begin
      value_mismatch("empty_o", empty_o, 0);
    end
    send_rsp(xfer_id[0]);
    await_empty();
    xfer_count_is(1);
  endtask

  task automatic coalesce_two_halves();
    logic [AddrWidth-1:0] addr;
    logic [63:0] lo_data;
    logic [63:0] hi_data;
    clear_xfers();
    addr    = 32'h0000_1a40;
    lo_data = random_bits(64);
    hi_data = random_bits(64);
    set_ack(1'b0);
    store_word(addr, 8'h0f, lo_data);
    store_word(addr, 8'hf0, hi_data);
    xfer_count_is(0);
    set_ack(1'b1);
    wait_xfers(1);
    check_xfer(0, addr, SIZE_DWORD, {hi_data[63:32], lo_data[31:0]});
    send_rsp(xfer_id[0]);
    await_empty();
    xfer_count_is(1);
  endtask

  // mask 0011_1001 goes out as byte 0, byte 3, half 4
  task automatic split_unaligned_mask();
    logic [AddrWidth-1:0] addr;
    logic [63:0] data;
    clear_xfers();
    addr = 32'h0000_2c88;
    data = random_bits(64);
    set_ack(1'b1);
    store_word(addr, 8'b0011_1001, data);
    wait_xfers(1);
    check_xfer(0, addr, SIZE_BYTE, replicate(data, 0, 1));
    send_rsp(xfer_id[0]);
    wait_xfers(2);
    check_xfer(1, addr + 3, SIZE_BYTE, replicate(data, 3, 1));
    send_rsp(xfer_id[1]);
    wait_xfers(3);
    check_xfer(2, addr + 4, SIZE_HALF, replicate(data, 4, 2));
    send_rsp(xfer_id[2]);
    await_empty();
    xfer_count_is(3);
  endtask

  task automatic rewrite_in_flight();
    logic [AddrWidth-1:0] addr;
    logic [63:0] first;
    logic [63:0] second;
    clear_xfers();
    addr   = 32'h0000_3f10;
    first  = random_bits(64);
    second = ~first;
    set_ack(1'b1);
    store_word(addr, 8'h04, first);
    wait_xfers(1);
    check_xfer(0, addr + 2, SIZE_BYTE, replicate(first, 2, 1));
    store_word(addr, 8'h04, second);
    // the rewritten byte waits for the response
    repeat (4) @(posedge clk_i);
    xfer_count_is(1);
    send_rsp(xfer_id[0]);
    wait_xfers(2);
    check_xfer(1, addr + 2, SIZE_BYTE, replicate(second, 2, 1));
    send_rsp(xfer_id[1]);
    await_empty();
    xfer_count_is(2);
  endtask

  task automatic fill_and_reorder();
    logic [AddrWidth-1:0] ent_addr [Depth];
    logic [63:0]          ent_data [Depth];
    logic [63:0]          rnd;
    int                   hits;
    clear_xfers();
    set_ack(1'b0);
    // tag bits [5:3] hold the entry index so all tags differ
    for (int i = 0; i < Depth; i++) begin
      rnd         = random_bits(AddrWidth - 6);
      ent_addr[i] = {rnd[AddrWidth-7:0], 3'(i), 3'b000};
      ent_data[i] = random_bits(64);
      store_word(ent_addr[i], 8'hff, ent_data[i]);
    end
    refuse_new_tag(ent_addr[0] ^ 32'h8000_0000);
    xfer_count_is(0);
    set_ack(1'b1);
    wait_xfers(MaxTx);
    // idle slots are handed out lowest first
    for (int k = 0; k < MaxTx; k++) begin
      checks++;
      if (xfer_id[k] !== IdWidth'(k)) begin
        value_mismatch("mem_id_o", xfer_id[k], k);
      end
    end
    // with every slot busy nothing may be requested
    repeat (4) begin
      @(negedge clk_i);
      checks++;
      if (mem_req_o !== 1'b0) begin
        value_mismatch("mem_req_o", mem_req_o, 0);
      end
    end
    xfer_count_is(MaxTx);
    answer_all_reverse();
    wait_xfers(Depth);
    answer_all_reverse();
    await_empty();
    xfer_count_is(Depth);
    for (int i = 0; i < Depth; i++) begin
      hits = 0;
      for (int t = 0; t < xfer_addr.size(); t++) begin
        if (xfer_addr[t] == ent_addr[i]) begin
          hits++;
          if (xfer_size[t] !== SIZE_DWORD) begin
            value_mismatch("mem_size_o", xfer_size[t], SIZE_DWORD);
          end
          if (xfer_data[t] !== ent_data[i]) begin
            value_mismatch("mem_data_o", xfer_data[t], ent_data[i]);
          end
        end
      end
      checks++;
      if (hits != 1) begin
        $display("entry %0d at 0x%0h was sent %0d times instead of once", i, ent_addr[i], hits);
        errors++;
      end
    end
  endtask

  ////////////////////////////////////////////////////////////
  // main sequence
  ////////////////////////////////////////////////////////////

  initial begin : p_main
    rst_ni     = 1'b0;
    wr_req_i   = 1'b0;
    wr_addr_i  = '0;
    wr_be_i    = '0;
    wr_data_i  = '0;
    mem_ack_i  = 1'b0;
    rsp_vld_i  = 1'b0;
    rsp_id_i   = '0;
    lfsr_state = 16'd75;
    errors     = 0;
    timeouts   = 0;
    checks     = 0;
    repeat (2) @(posedge clk_i);
    rst_ni <= 1'b1;
    @(negedge clk_i);
    checks++;
    if (wr_gnt_o !== 1'b0) begin
      value_mismatch("wr_gnt_o", wr_gnt_o, 0);
    end
    if (mem_req_o !== 1'b0) begin
      value_mismatch("mem_req_o", mem_req_o, 0);
    end
    if (empty_o !== 1'b1) begin
      value_mismatch("empty_o", empty_o, 1);
    end
    send_full_dword();
    coalesce_two_halves();
    split_unaligned_mask();
    rewrite_in_flight();
    fill_and_reorder();
    $display("checks %0d, errors %0d, timeouts %0d", checks, errors, timeouts);
    if (errors == 0 && timeouts == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

endmodule

/* wbuf_issue.sv */
// Depth must be a power of two and an entry with a transfer in flight sends nothing
`timescale 1ns/1ps

module wbuf_issue #(
  parameter int Depth     = 8,
  parameter int MaxTx     = 4,
  parameter int AddrWidth = 32
) (
  input  logic                                                  clk_i,
  input  logic                                                  rst_ni,
  input  logic [Depth-1:0][wbuf_pkg::WORD_BYTES-1:0]            dirty_be_i,
  input  logic [Depth-1:0][AddrWidth-wbuf_pkg::OFF_BITS-1:0]    tag_i,
  input  logic [Depth-1:0][wbuf_pkg::WORD_WIDTH-1:0]            data_i,
  input  logic                                                  slot_free_i,
  input  logic [$clog2(MaxTx)-1:0]                              free_id_i,
  // memory write request
  output logic                                                  mem_req_o,
  input  logic                                                  mem_ack_i,
  output logic [AddrWidth-1:0]                                  mem_addr_o,
  output mem_pkg::mem_size_e                                    mem_size_o,
  output logic [mem_pkg::MEM_DATA_WIDTH-1:0]                    mem_data_o,
  output logic [$clog2(MaxTx)-1:0]                              mem_id_o,
  // accepted transfer
  output logic                                                  fire_o,
  output logic [$clog2(Depth)-1:0]                              fire_ptr_o,
  output logic [wbuf_pkg::WORD_BYTES-1:0]                       fire_be_o
);

  import wbuf_pkg::*;
  import mem_pkg::*;

  localparam int PtrWidth = $clog2(Depth);

  logic [PtrWidth-1:0]   rr_q;
  logic [PtrWidth-1:0]   sel_ptr;
  logic                  sel_vld;
  logic [WORD_BYTES-1:0] sel_be;
  logic [WORD_BYTES-1:0] span;
  logic [OFF_BITS-1:0]   sel_off;
  logic [WORD_WIDTH-1:0] sel_word;

  ////////////////////////////////////////////////////////////
  // round-robin entry choice
  ////////////////////////////////////////////////////////////

  // first sendable entry at or after rr_q
  always_comb begin : p_pick
    logic [PtrWidth-1:0] idx;
    sel_ptr = rr_q;
    sel_vld = 1'b0;
    for (int i = Depth - 1; i >= 0; i--) begin
      idx = rr_q + PtrWidth'(i);
      if (|dirty_be_i[idx]) begin
        sel_ptr = idx;
        sel_vld = 1'b1;
      end
    end
  end

  // a pending request parks the pointer on its entry so the choice holds
  always_ff @(posedge clk_i or negedge rst_ni) begin : p_rr
    if (!rst_ni) begin
      rr_q <= '0;
    end else if (fire_o) begin
      rr_q <= sel_ptr + 1'b1;
    end else if (mem_req_o) begin
      rr_q <= sel_ptr;
    end
  end

  ////////////////////////////////////////////////////////////
  // aligned size split and replication
  ////////////////////////////////////////////////////////////

  always_comb begin : p_size
    sel_be  = dirty_be_i[sel_ptr];
    sel_off = '0;
    for (int j = WORD_BYTES - 1; j >= 0; j--) begin
      if (sel_be[j]) begin
        sel_off = OFF_BITS'(j);
      end
    end
    // largest aligned span starting at the offset that is fully dirty
    span = sel_be >> sel_off;
    if ((sel_off == '0) && (&span)) begin
      mem_size_o = SIZE_DWORD;
    end else if ((sel_off[1:0] == 2'b00) && (&span[3:0])) begin
      mem_size_o = SIZE_WORD;
    end else if (!sel_off[0] && (&span[1:0])) begin
      mem_size_o = SIZE_HALF;
    end else begin
      mem_size_o = SIZE_BYTE;
    end
  end

  assign fire_be_o = WORD_BYTES'((1 << size_bytes(mem_size_o)) - 1) << sel_off;

  // chosen bytes moved down to bit 0 and then repeated over the bus
  assign sel_word = data_i[sel_ptr] >> {sel_off, 3'b000};

  always_comb begin : p_data
    case (mem_size_o)
      SIZE_BYTE: mem_data_o = {8{sel_word[7:0]}};
      SIZE_HALF: mem_data_o = {4{sel_word[15:0]}};
      SIZE_WORD: mem_data_o = {2{sel_word[31:0]}};
      default:   mem_data_o = sel_word;
    endcase
  end

  assign mem_addr_o = {tag_i[sel_ptr], sel_off};
  assign mem_req_o  = sel_vld && slot_free_i;
  assign mem_id_o   = free_id_i;
  assign fire_o     = mem_req_o && mem_ack_i;
  assign fire_ptr_o = sel_ptr;

  ////////////////////////////////////////////////////////////
  // assertions
  ////////////////////////////////////////////////////////////

  // the sent span is never empty and holds only sendable bytes
  a_fire_be: assert property (@(posedge clk_i) disable iff (!rst_ni)
    fire_o |-> ((fire_be_o != '0) && ((fire_be_o & ~sel_be) == '0)))
    else $error("wbuf_issue: transfer accepted with an empty or unsendable byte mask");

  // an unanswered request stays up on the same entry
  a_req_hold: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (mem_req_o && !mem_ack_i) |=> (mem_req_o && (fire_ptr_o == $past(fire_ptr_o))))
    else $error("wbuf_issue: pending request dropped or moved to another entry");

endmodule

/* wbuf_pkg.sv */
// write buffer constants; entries are one 8-byte dword each, bytes tracked individually
package wbuf_pkg;

  // bytes per buffer word
  localparam int WORD_BYTES = 8;

  // data bits per buffer word
  localparam int WORD_WIDTH = 64;

  // width of the byte offset inside a word
  localparam int OFF_BITS = 3;

  // state of a single buffered byte
  // bit 0 marks data still to be sent, bit 1 marks a transfer in flight
  // FREE            no data, byte is not part of the entry
  // DIRTY           written and waiting to be sent
  // INFLIGHT        sent, waiting for the write response
  // INFLIGHT_DIRTY  rewritten while in flight, must go out again after the response
  typedef enum logic [1:0] {
    FREE           = 2'b00,
    DIRTY          = 2'b01,
    INFLIGHT       = 2'b10,
    INFLIGHT_DIRTY = 2'b11
  } byte_state_e;

endpackage

/* wbuf_store.sv */
// Depth must be a power of two and each dword tag owns at most one entry
`timescale 1ns/1ps

module wbuf_store #(
  parameter int Depth     = 8,
  parameter int AddrWidth = 32
) (
  input  logic                                                  clk_i,
  input  logic                                                  rst_ni,
  // store port from the core
  input  logic                                                  wr_req_i,
  input  logic [AddrWidth-1:0]                                  wr_addr_i,
  input  logic [wbuf_pkg::WORD_BYTES-1:0]                       wr_be_i,
  input  logic [wbuf_pkg::WORD_WIDTH-1:0]                       wr_data_i,
  output logic                                                  wr_gnt_o,
  // entry contents towards the issue logic
  output logic [Depth-1:0][wbuf_pkg::WORD_BYTES-1:0]            dirty_be_o,
  output logic [Depth-1:0][AddrWidth-wbuf_pkg::OFF_BITS-1:0]    tag_o,
  output logic [Depth-1:0][wbuf_pkg::WORD_WIDTH-1:0]            data_o,
  // bytes handed to memory
  input  logic                                                  fire_i,
  input  logic [$clog2(Depth)-1:0]                              fire_ptr_i,
  input  logic [wbuf_pkg::WORD_BYTES-1:0]                       fire_be_i,
  // bytes released by a write response
  input  logic                                                  evict_i,
  input  logic [$clog2(Depth)-1:0]                              evict_ptr_i,
  input  logic [wbuf_pkg::WORD_BYTES-1:0]                       evict_be_i,
  output logic                                                  empty_o
);

  import wbuf_pkg::*;

  localparam int PtrWidth = $clog2(Depth);
  localparam int TagWidth = AddrWidth - OFF_BITS;

  byte_state_e                    state_q [Depth][WORD_BYTES];
  byte_state_e                    state_d [Depth][WORD_BYTES];
  logic [Depth-1:0][TagWidth-1:0] tag_q;
  logic [Depth-1:0][WORD_WIDTH-1:0] data_q;

  logic [TagWidth-1:0] wr_tag;
  logic [Depth-1:0]    valid;
  logic [Depth-1:0]    inflight;
  logic [Depth-1:0]    hit_oh;
  logic [PtrWidth-1:0] hit_ptr;
  logic [PtrWidth-1:0] free_ptr;
  logic [PtrWidth-1:0] wr_ptr;
  logic                full;

  ////////////////////////////////////////////////////////////
  // entry flags and tag compare
  ////////////////////////////////////////////////////////////

  assign wr_tag = wr_addr_i[AddrWidth-1:OFF_BITS];

  always_comb begin : p_flags
    for (int k = 0; k < Depth; k++) begin
      valid[k]    = 1'b0;
      inflight[k] = 1'b0;
      for (int j = 0; j < WORD_BYTES; j++) begin
        valid[k]    = valid[k] | (state_q[k][j] != FREE);
        inflight[k] = inflight[k] | (state_q[k][j] inside {INFLIGHT, INFLIGHT_DIRTY});
      end
      hit_oh[k] = valid[k] && (tag_q[k] == wr_tag);
      // an entry with a transfer in flight sends nothing since responses may overtake
      for (int j = 0; j < WORD_BYTES; j++) begin
        dirty_be_o[k][j] = (state_q[k][j] == DIRTY) && !inflight[k];
      end
    end
  end

  // lowest hit and lowest free entry
  always_comb begin : p_ptrs
    hit_ptr  = '0;
    free_ptr = '0;
    for (int k = Depth - 1; k >= 0; k--) begin
      if (hit_oh[k]) begin
        hit_ptr = PtrWidth'(k);
      end
      if (!valid[k]) begin
        free_ptr = PtrWidth'(k);
      end
    end
  end

  assign full     = &valid;
  assign wr_ptr   = (|hit_oh) ? hit_ptr : free_ptr;
  assign wr_gnt_o = wr_req_i && ((|hit_oh) || !full);
  assign empty_o  = ~(|valid);
  assign tag_o    = tag_q;
  assign data_o   = data_q;

  ////////////////////////////////////////////////////////////
  // byte state update
  ////////////////////////////////////////////////////////////

  // eviction first, then transfer, then the new store on top
  always_comb begin : p_next
    state_d = state_q;
    if (evict_i) begin
      for (int j = 0; j < WORD_BYTES; j++) begin
        if (evict_be_i[j]) begin
          case (state_q[evict_ptr_i][j])
            INFLIGHT:       state_d[evict_ptr_i][j] = FREE;
            INFLIGHT_DIRTY: state_d[evict_ptr_i][j] = DIRTY;
            default:        state_d[evict_ptr_i][j] = state_q[evict_ptr_i][j];
          endcase
        end
      end
    end
    if (fire_i) begin
      for (int j = 0; j < WORD_BYTES; j++) begin
        if (fire_be_i[j]) begin
          state_d[fire_ptr_i][j] = INFLIGHT;
        end
      end
    end
    // rewriting an in-flight byte keeps it blocked until its response
    if (wr_gnt_o) begin
      for (int j = 0; j < WORD_BYTES; j++) begin
        if (wr_be_i[j]) begin
          if (state_d[wr_ptr][j] inside {INFLIGHT, INFLIGHT_DIRTY}) begin
            state_d[wr_ptr][j] = INFLIGHT_DIRTY;
          end else begin
            state_d[wr_ptr][j] = DIRTY;
          end
        end
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin : p_state
    if (!rst_ni) begin
      state_q <= '{default: FREE};
    end else begin
      state_q <= state_d;
    end
  end

  // only enabled bytes of the data overwrite
  always_ff @(posedge clk_i) begin : p_payload
    if (wr_gnt_o) begin
      tag_q[wr_ptr] <= wr_tag;
      for (int j = 0; j < WORD_BYTES; j++) begin
        if (wr_be_i[j]) begin
          data_q[wr_ptr][8*j +: 8] <= wr_data_i[8*j +: 8];
        end
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // assertions
  ////////////////////////////////////////////////////////////

  // coalescing must never leave two entries with the same tag
  a_hit_onehot: assert property (@(posedge clk_i) disable iff (!rst_ni)
    wr_req_i |-> $onehot0(hit_oh))
    else $error("wbuf_store: store tag hits more than one entry");

  // a new tag only lands on an unused entry and never on a full buffer
  a_full_no_gnt: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (wr_gnt_o && !(|hit_oh)) |-> !valid[free_ptr])
    else $error("wbuf_store: grant for a new tag while the buffer is full");

endmodule

/* wbuf_top.sv */
// coalescing write buffer top; Depth and MaxTx must be powers of two, AddrWidth above 3
`timescale 1ns/1ps

module wbuf_top #(
  parameter int Depth     = 8,
  parameter int MaxTx     = 4,
  parameter int AddrWidth = 32
) (
  input  logic                               clk_i,
  input  logic                               rst_ni,
  // store port
  input  logic                               wr_req_i,
  input  logic [AddrWidth-1:0]               wr_addr_i,
  input  logic [wbuf_pkg::WORD_BYTES-1:0]    wr_be_i,
  input  logic [wbuf_pkg::WORD_WIDTH-1:0]    wr_data_i,
  output logic                               wr_gnt_o,
  // memory write request
  output logic                               mem_req_o,
  input  logic                               mem_ack_i,
  output logic [AddrWidth-1:0]               mem_addr_o,
  output mem_pkg::mem_size_e                 mem_size_o,
  output logic [mem_pkg::MEM_DATA_WIDTH-1:0] mem_data_o,
  output logic [$clog2(MaxTx)-1:0]           mem_id_o,
  // write response
  input  logic                               rsp_vld_i,
  input  logic [$clog2(MaxTx)-1:0]           rsp_id_i,
  output logic                               empty_o
);

  import wbuf_pkg::*;

  localparam int PtrWidth = $clog2(Depth);
  localparam int TagWidth = AddrWidth - OFF_BITS;

  // store to issue
  logic [Depth-1:0][WORD_BYTES-1:0] dirty_be;
  logic [Depth-1:0][TagWidth-1:0]   tag;
  logic [Depth-1:0][WORD_WIDTH-1:0] data;
  // issue to store and tracker
  logic                             fire;
  logic [PtrWidth-1:0]              fire_ptr;
  logic [WORD_BYTES-1:0]            fire_be;
  // tracker to issue and store
  logic                             slot_free;
  logic [$clog2(MaxTx)-1:0]         free_id;
  logic                             evict;
  logic [PtrWidth-1:0]              evict_ptr;
  logic [WORD_BYTES-1:0]            evict_be;

  wbuf_store #(
    .Depth     (Depth),
    .AddrWidth (AddrWidth)
  ) i_store (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .wr_req_i    (wr_req_i),
    .wr_addr_i   (wr_addr_i),
    .wr_be_i     (wr_be_i),
    .wr_data_i   (wr_data_i),
    .wr_gnt_o    (wr_gnt_o),
    .dirty_be_o  (dirty_be),
    .tag_o       (tag),
    .data_o      (data),
    .fire_i      (fire),
    .fire_ptr_i  (fire_ptr),
    .fire_be_i   (fire_be),
    .evict_i     (evict),
    .evict_ptr_i (evict_ptr),
    .evict_be_i  (evict_be),
    .empty_o     (empty_o)
  );

  wbuf_issue #(
    .Depth     (Depth),
    .MaxTx     (MaxTx),
    .AddrWidth (AddrWidth)
  ) i_issue (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .dirty_be_i  (dirty_be),
    .tag_i       (tag),
    .data_i      (data),
    .slot_free_i (slot_free),
    .free_id_i   (free_id),
    .mem_req_o   (mem_req_o),
    .mem_ack_i   (mem_ack_i),
    .mem_addr_o  (mem_addr_o),
    .mem_size_o  (mem_size_o),
    .mem_data_o  (mem_data_o),
    .mem_id_o    (mem_id_o),
    .fire_o      (fire),
    .fire_ptr_o  (fire_ptr),
    .fire_be_o   (fire_be)
  );

  wbuf_tx_track #(
    .Depth (Depth),
    .MaxTx (MaxTx)
  ) i_tx_track (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .fire_i      (fire),
    .fire_ptr_i  (fire_ptr),
    .fire_be_i   (fire_be),
    .mem_id_i    (mem_id_o),
    .rsp_vld_i   (rsp_vld_i),
    .rsp_id_i    (rsp_id_i),
    .slot_free_o (slot_free),
    .free_id_o   (free_id),
    .evict_o     (evict),
    .evict_ptr_o (evict_ptr),
    .evict_be_o  (evict_be)
  );

endmodule

/* wbuf_tx_track.sv */
// transaction tracker; MaxTx must be a power of two, at most one response per slot in flight
`timescale 1ns/1ps

module wbuf_tx_track #(
  parameter int Depth = 8,
  parameter int MaxTx = 4
) (
  input  logic                            clk_i,
  input  logic                            rst_ni,
  // transfer accepted by memory
  input  logic                            fire_i,
  input  logic [$clog2(Depth)-1:0]        fire_ptr_i,
  input  logic [wbuf_pkg::WORD_BYTES-1:0] fire_be_i,
  input  logic [$clog2(MaxTx)-1:0]        mem_id_i,
  // write responses, no back-pressure
  input  logic                            rsp_vld_i,
  input  logic [$clog2(MaxTx)-1:0]        rsp_id_i,
  output logic                            slot_free_o,
  output logic [$clog2(MaxTx)-1:0]        free_id_o,
  // byte release towards the store
  output logic                            evict_o,
  output logic [$clog2(Depth)-1:0]        evict_ptr_o,
  output logic [wbuf_pkg::WORD_BYTES-1:0] evict_be_o
);

  import wbuf_pkg::*;

  localparam int IdWidth  = $clog2(MaxTx);
  localparam int PtrWidth = $clog2(Depth);
  localparam int CntWidth = $clog2(MaxTx + 1);

  logic [MaxTx-1:0]                 busy_q;
  logic [MaxTx-1:0][PtrWidth-1:0]   ptr_q;
  logic [MaxTx-1:0][WORD_BYTES-1:0] be_q;
  logic [MaxTx-1:0][IdWidth-1:0]    fifo_q;
  logic [IdWidth-1:0]               wr_q;
  logic [IdWidth-1:0]               rd_q;
  logic [CntWidth-1:0]              cnt_q;
  logic [IdWidth-1:0]               rtrn_id;

  ////////////////////////////////////////////////////////////
  // slot table
  ////////////////////////////////////////////////////////////

  // lowest idle slot is offered to the issue logic
  always_comb begin : p_free
    free_id_o = '0;
    for (int i = MaxTx - 1; i >= 0; i--) begin
      if (!busy_q[i]) begin
        free_id_o = IdWidth'(i);
      end
    end
  end

  assign slot_free_o = ~(&busy_q);

  always_ff @(posedge clk_i or negedge rst_ni) begin : p_busy
    if (!rst_ni) begin
      busy_q <= '0;
    end else begin
      if (evict_o) begin
        busy_q[rtrn_id] <= 1'b0;
      end
      if (fire_i) begin
        busy_q[mem_id_i] <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin : p_slot
    if (fire_i) begin
      ptr_q[mem_id_i] <= fire_ptr_i;
      be_q[mem_id_i]  <= fire_be_i;
    end
  end

  ////////////////////////////////////////////////////////////
  // response FIFO, registered output
  ////////////////////////////////////////////////////////////

  // one pop per cycle, never in the push cycle
  assign evict_o     = (cnt_q != '0);
  assign rtrn_id     = fifo_q[rd_q];
  assign evict_ptr_o = ptr_q[rtrn_id];
  assign evict_be_o  = be_q[rtrn_id];

  always_ff @(posedge clk_i or negedge rst_ni) begin : p_fifo_ctrl
    if (!rst_ni) begin
      wr_q  <= '0;
      rd_q  <= '0;
      cnt_q <= '0;
    end else begin
      if (rsp_vld_i) begin
        wr_q <= wr_q + 1'b1;
      end
      if (evict_o) begin
        rd_q <= rd_q + 1'b1;
      end
      cnt_q <= cnt_q + CntWidth'(rsp_vld_i) - CntWidth'(evict_o);
    end
  end

  always_ff @(posedge clk_i) begin : p_fifo_mem
    if (rsp_vld_i) begin
      fifo_q[wr_q] <= rsp_id_i;
    end
  end

  ////////////////////////////////////////////////////////////
  // assertions
  ////////////////////////////////////////////////////////////

  a_rsp_busy: assert property (@(posedge clk_i) disable iff (!rst_ni)
    rsp_vld_i |-> busy_q[rsp_id_i])
    else $error("wbuf_tx_track: response for idle slot %0d", rsp_id_i);

  a_alloc_free: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (fire_i && evict_o) |-> (mem_id_i != rtrn_id))
    else $error("wbuf_tx_track: slot %0d allocated and freed together", mem_id_i);

endmodule
